/* rtl/wload_pkg.sv */
// shared definitions for the weight tile loader
// widths, APB register map, burst FSM states and bus structs

package wload_pkg;

    localparam int XAW  = 32;
    localparam int XDW  = 128;
    localparam int DW   = 32;
    localparam int CW   = 16;
    localparam int WCNT = XDW / DW;

    // APB register offsets
    localparam logic [7:0] REG_CTRL   = 8'h00;
    localparam logic [7:0] REG_BASE   = 8'h04;
    localparam logic [7:0] REG_LEN    = 8'h08;
    localparam logic [7:0] REG_STATUS = 8'h0C;
    localparam logic [7:0] REG_SUM    = 8'h10;
    localparam logic [7:0] REG_COUNT  = 8'h14;

    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        WAIT_DONE,
        FINISH
    } burst_state_e;

    typedef struct packed {
        logic [XAW-1:0] base;
        logic [CW-1:0]  len;
        logic           sink_en;
    } load_cfg_t;

    // request towards the read master with the length in bytes
    typedef struct packed {
        logic [XAW-1:0] read_base;
        logic [CW-1:0]  read_length;
        logic           fixed_location;
        logic           go;
    } rmst_cmd_t;

    typedef struct packed {
        logic           done;
        logic           data_available;
        logic [XDW-1:0] buffer_data;
    } rmst_rsp_t;

endpackage

/* rtl/wload_apb_regs.sv */
// APB register block for the weight loader
// holds base, length and sink enable, launches loads, reports status

`timescale 1ns/100ps

module wload_apb_regs (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  logic [7:0]                 paddr,
    input  logic [31:0]                pwdata,
    input  logic [wload_pkg::DW-1:0]   sum,
    input  logic [wload_pkg::CW-1:0]   count,
    input  logic                       load_done,
    output logic [31:0]                prdata,
    output logic                       pready,
    output wload_pkg::load_cfg_t       cfg,
    output logic                       start
);

    logic wr_en;
    logic busy;
    logic done;

    // writes complete in the access phase without wait states
    assign wr_en  = psel & penable & pwrite;
    assign pready = 1'b1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cfg   <= '0;
            start <= 1'b0;
            busy  <= 1'b0;
            done  <= 1'b0;
        end else begin
            start <= 1'b0;
            if (wr_en) begin
                case (paddr)
                    wload_pkg::REG_CTRL: begin
                        cfg.sink_en <= pwdata[1];
                        // a start while a load runs is dropped
                        start <= pwdata[0] & ~busy;
                    end
                    wload_pkg::REG_BASE: cfg.base <= pwdata[wload_pkg::XAW-1:0];
                    wload_pkg::REG_LEN:  cfg.len  <= {pwdata[wload_pkg::CW-1:2], 2'b00};
                    default: ;
                endcase
            end
            if (start) begin
                busy <= 1'b1;
                done <= 1'b0;
            end else if (busy && load_done) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end

    // start bit always reads back as zero
    always_comb begin
        prdata = '0;
        case (paddr)
            wload_pkg::REG_CTRL:   prdata = {30'b0, cfg.sink_en, 1'b0};
            wload_pkg::REG_BASE:   prdata = 32'(cfg.base);
            wload_pkg::REG_LEN:    prdata = 32'(cfg.len);
            wload_pkg::REG_STATUS: prdata = {30'b0, done, busy};
            wload_pkg::REG_SUM:    prdata = 32'(sum);
            wload_pkg::REG_COUNT:  prdata = 32'(count);
            default:               prdata = '0;
        endcase
    end

endmodule

/* rtl/rmst_burst_ctrl.sv */
// burst controller for the read master
// splits a load into bursts of up to BLEN words, gated on FIFO room

`timescale 1ns/100ps

module rmst_burst_ctrl #(
    parameter int BLEN       = 8,
    parameter int FIFO_DEPTH = 32
) (
    input  logic                     clk,
    input  logic                     rst,
    input  wload_pkg::load_cfg_t     cfg,
    input  logic                     start,
    input  logic                     rsp_done,
    input  logic                     word_pushed,
    input  logic [wload_pkg::CW-1:0] fifo_free,
    output wload_pkg::rmst_cmd_t     cmd
);

    localparam int OW = $clog2(FIFO_DEPTH + 1);

    wload_pkg::burst_state_e    state;
    logic [wload_pkg::XAW-1:0]  addr;
    logic [wload_pkg::CW-1:0]   remaining;
    logic [wload_pkg::CW-1:0]   burst_words;
    logic [wload_pkg::CW-1:0]   need;
    logic [OW-1:0]              outstanding;
    logic                       go;

    assign burst_words = (remaining > wload_pkg::CW'(BLEN)) ? wload_pkg::CW'(BLEN) : remaining;

    // words already in flight still need a slot in the FIFO
    assign need = wload_pkg::CW'(outstanding) + burst_words;
    assign go   = (state == wload_pkg::ISSUE) && rsp_done && (remaining != '0) &&
                  (need <= fifo_free);

    always_comb begin
        cmd.read_base      = addr;
        cmd.read_length    = burst_words << 2;
        cmd.fixed_location = 1'b0;
        cmd.go             = go;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= wload_pkg::IDLE;
            addr      <= '0;
            remaining <= '0;
        end else begin
            case (state)
                wload_pkg::IDLE: begin
                    if (start) begin
                        addr      <= cfg.base;
                        remaining <= cfg.len;
                        state     <= wload_pkg::ISSUE;
                    end
                end
                wload_pkg::ISSUE: begin
                    if (remaining == '0) begin
                        state <= wload_pkg::FINISH;
                    end else if (go) begin
                        addr      <= addr + wload_pkg::XAW'({burst_words, 2'b00});
                        remaining <= remaining - burst_words;
                        state     <= wload_pkg::WAIT_DONE;
                    end
                end
                // master drops done the cycle after go
                wload_pkg::WAIT_DONE: begin
                    if (rsp_done) begin
                        state <= wload_pkg::ISSUE;
                    end
                end
                default: state <= wload_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            outstanding <= '0;
        end else begin
            outstanding <= outstanding + (go ? OW'(burst_words) : OW'(0)) - OW'(word_pushed);
        end
    end

endmodule

/* rtl/rmst_word_unpack.sv */
// beat unpacker between the read master and the weight FIFO
// one 128-bit beat becomes four 32-bit pushes, low word first

`timescale 1ns/100ps

module rmst_word_unpack (
    input  logic                     clk,
    input  logic                     rst,
    input  wload_pkg::rmst_rsp_t     rsp,
    input  logic                     fifo_full,
    output logic                     read_buffer,
    output logic                     push,
    output logic [wload_pkg::DW-1:0] wdata
);

    logic [wload_pkg::XDW-1:0]  beat;
    logic [wload_pkg::WCNT-1:0] word_vld;

    // ring is empty once the last word has shifted out
    assign read_buffer = (word_vld == '0) && rsp.data_available;
    assign push        = (word_vld != '0) && !fifo_full;
    assign wdata       = beat[wload_pkg::DW-1:0];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            word_vld <= '0;
        end else if (read_buffer) begin
            word_vld <= wload_pkg::WCNT'(1);
        end else if (push) begin
            word_vld <= word_vld << 1;
        end
    end

    always_ff @(posedge clk) begin
        if (read_buffer) begin
            beat <= rsp.buffer_data;
        end else if (push) begin
            beat <= beat >> wload_pkg::DW;
        end
    end

endmodule

/* rtl/weight_fifo.sv */
// synchronous FIFO for weight words
// circular buffer with occupancy count and free-slot report

`timescale 1ns/100ps

module weight_fifo #(
    parameter int FIFO_DEPTH = 32
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     push,
    input  logic [wload_pkg::DW-1:0] wdata,
    input  logic                     pop,
    output logic [wload_pkg::DW-1:0] rdata,
    output logic                     empty,
    output logic                     full,
    output logic [wload_pkg::CW-1:0] free
);

    localparam int AW = $clog2(FIFO_DEPTH);

    logic [wload_pkg::DW-1:0] mem [FIFO_DEPTH];
    logic [AW-1:0]            wr_ptr;
    logic [AW-1:0]            rd_ptr;
    logic [AW:0]              used;
    logic                     wr_en;
    logic                     rd_en;

    assign wr_en = push && !full;
    assign rd_en = pop && !empty;
    assign empty = (used == '0);
    assign full  = (used == (AW+1)'(FIFO_DEPTH));
    assign free  = wload_pkg::CW'(FIFO_DEPTH) - wload_pkg::CW'(used);

    // head word is visible without a read latency
    assign rdata = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= wdata;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            used   <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            used <= used + (AW+1)'(wr_en) - (AW+1)'(rd_en);
        end
    end

endmodule

/* rtl/weight_tile_sink.sv */
// tile sink on the compute side
// pops weights, keeps count and wrapping sum, flags completion

`timescale 1ns/100ps

module weight_tile_sink (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     clear,
    input  wload_pkg::load_cfg_t     cfg,
    input  logic [wload_pkg::DW-1:0] rdata,
    input  logic                     empty,
    output logic                     pop,
    output logic [wload_pkg::DW-1:0] sum,
    output logic [wload_pkg::CW-1:0] count,
    output logic                     load_done
);

    assign pop = cfg.sink_en && !empty;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sum       <= '0;
            count     <= '0;
            load_done <= 1'b0;
        end else begin
            load_done <= 1'b0;
            if (clear) begin
                sum   <= '0;
                count <= '0;
            end else if (pop) begin
                sum   <= sum + rdata;
                count <= count + 1'b1;
                // pulse lines up with count reaching len
                load_done <= (count + 1'b1 == cfg.len);
            end
        end
    end

endmodule

/* rtl/weight_load_top.sv */
// weight tile loader top level
// APB registers, burst controller, unpacker, weight FIFO and tile sink

`timescale 1ns/100ps

module weight_load_top #(
    parameter int BLEN       = 8,
    parameter int FIFO_DEPTH = 32
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 psel,
    input  logic                 penable,
    input  logic                 pwrite,
    input  logic [7:0]           paddr,
    input  logic [31:0]          pwdata,
    input  wload_pkg::rmst_rsp_t rsp,
    output logic [31:0]          prdata,
    output logic                 pready,
    output wload_pkg::rmst_cmd_t cmd,
    output logic                 read_buffer
);

    wload_pkg::load_cfg_t     cfg;
    logic                     start;
    logic [wload_pkg::DW-1:0] sum;
    logic [wload_pkg::CW-1:0] count;
    logic                     load_done;
    logic                     push;
    logic [wload_pkg::DW-1:0] wdata;
    logic                     pop;
    logic [wload_pkg::DW-1:0] rdata;
    logic                     empty;
    logic                     full;
    logic [wload_pkg::CW-1:0] free;

    wload_apb_regs regs0 (
        .clk       (clk),
        .rst       (rst),
        .psel      (psel),
        .penable   (penable),
        .pwrite    (pwrite),
        .paddr     (paddr),
        .pwdata    (pwdata),
        .sum       (sum),
        .count     (count),
        .load_done (load_done),
        .prdata    (prdata),
        .pready    (pready),
        .cfg       (cfg),
        .start     (start)
    );

    rmst_burst_ctrl #(
        .BLEN       (BLEN),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) burst0 (
        .clk         (clk),
        .rst         (rst),
        .cfg         (cfg),
        .start       (start),
        .rsp_done    (rsp.done),
        .word_pushed (push),
        .fifo_free   (free),
        .cmd         (cmd)
    );

    rmst_word_unpack unpack0 (
        .clk         (clk),
        .rst         (rst),
        .rsp         (rsp),
        .fifo_full   (full),
        .read_buffer (read_buffer),
        .push        (push),
        .wdata       (wdata)
    );

    weight_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo0 (
        .clk   (clk),
        .rst   (rst),
        .push  (push),
        .wdata (wdata),
        .pop   (pop),
        .rdata (rdata),
        .empty (empty),
        .full  (full),
        .free  (free)
    );

    // start also clears the sink totals
    weight_tile_sink sink0 (
        .clk       (clk),
        .rst       (rst),
        .clear     (start),
        .cfg       (cfg),
        .rdata     (rdata),
        .empty     (empty),
        .pop       (pop),
        .sum       (sum),
        .count     (count),
        .load_done (load_done)
    );

endmodule

/* tests/tb_weight_load.sv */
// testbench for the weight tile loader
// APB driver tasks, read-master memory model, load table with stalls,
// value check task and cycle timeout

`timescale 1ns/100ps

module tb_weight_load;

    localparam int BLEN       = 8;
    localparam int FIFO_DEPTH = 32;
    localparam int NUM_LOADS  = 5;

    typedef struct packed {
        logic [31:0] base;
        logic [15:0] len;
        logic [15:0] stall;
        logic [31:0] exp_sum;
    } load_entry_t;

    logic                 clk;
    logic                 rst;
    logic                 psel;
    logic                 penable;
    logic                 pwrite;
    logic [7:0]           paddr;
    logic [31:0]          pwdata;
    logic [31:0]          prdata;
    logic                 pready;
    logic                 read_buffer;
    wload_pkg::rmst_rsp_t rsp;
    wload_pkg::rmst_cmd_t cmd;

    load_entry_t          loads [NUM_LOADS];
    integer               seed;
    int                   checks;
    int                   errors;
    int                   cycles;
    int                   limit;
    int                   early_activity;
    logic                 started;

    // read-master model state
    logic                 go_seen;
    logic                 rb_seen;
    logic                 pop_seen;
    logic                 done_at_go;
    wload_pkg::rmst_cmd_t cmd_seen;
    logic [31:0]          beat_addr;
    int                   beats_left;
    int                   delay;
    logic [31:0]          next_base;
    int                   req_bytes;
    int                   req_words;
    int                   popped;

    weight_load_top #(
        .BLEN       (BLEN),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut0 (
        .clk         (clk),
        .rst         (rst),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .rsp         (rsp),
        .prdata      (prdata),
        .pready      (pready),
        .cmd         (cmd),
        .read_buffer (read_buffer)
    );

    always #50 clk = ~clk;

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        checks = checks + 1;
        if (actual !== expected) begin
            errors = errors + 1;
            $display("Fail at %0t ns: %s, got %h, expected %h", $time, msg, actual, expected);
        end
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        // prdata sampled at the end of the access cycle
        @(posedge clk);
        data = prdata;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // the word at byte address a holds a*3+1
    function automatic logic [31:0] word_at(input logic [31:0] a);
        return a * 32'd3 + 32'd1;
    endfunction

    function automatic logic [127:0] beat_at(input logic [31:0] a);
        return {word_at(a + 32'd12), word_at(a + 32'd8), word_at(a + 32'd4), word_at(a)};
    endfunction

    // capture what the DUT saw at each rising edge
    always @(posedge clk) begin
        go_seen    <= cmd.go;
        cmd_seen   <= cmd;
        rb_seen    <= read_buffer;
        pop_seen   <= dut0.pop;
        done_at_go <= rsp.done;
        if (!rst && !started && (cmd.go || read_buffer || dut0.pop)) begin
            early_activity <= early_activity + 1;
        end
    end

    // read-master model drives its outputs on the falling edge
    always @(negedge clk) begin
        if (rst) begin
            rsp        = '0;
            rsp.done   = 1'b1;
            beats_left = 0;
            delay      = 0;
        end else begin
            if (pop_seen) begin
                popped = popped + 1;
            end
            if (rb_seen) begin
                beat_addr  = beat_addr + 32'd16;
                beats_left = beats_left - 1;
                if (beats_left == 0) begin
                    rsp.done = 1'b1;
                end
            end
            if (go_seen) begin
                check_value(32'(done_at_go), 32'd1, "go issued while done was low");
                check_value(32'(cmd_seen.read_length <= BLEN * 4), 32'd1,
                            "burst longer than BLEN words");
                check_value(32'(cmd_seen.fixed_location), 32'd0,
                            "fixed_location set on a burst");
                check_value(cmd_seen.read_base, next_base, "burst base not contiguous");
                next_base  = cmd_seen.read_base + 32'(cmd_seen.read_length);
                req_bytes  = req_bytes + int'(cmd_seen.read_length);
                req_words  = req_words + int'(cmd_seen.read_length) / 4;
                check_value(32'(req_words - popped <= FIFO_DEPTH), 32'd1,
                            "outstanding words exceed FIFO depth");
                beat_addr  = cmd_seen.read_base;
                beats_left = int'(cmd_seen.read_length) / 16;
                rsp.done   = 1'b0;
                delay      = $random(seed) & 7;
            end
            if (delay != 0) begin
                delay = delay - 1;
                rsp.data_available = 1'b0;
            end else if (beats_left != 0) begin
                rsp.data_available = (($random(seed) & 1) != 0);
            end else begin
                rsp.data_available = 1'b0;
            end
            rsp.buffer_data = beat_at(beat_addr);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("run timed out after %0d cycles, load did not complete", cycles);
            errors = errors + 1;
            $display("checks: %0d, errors: %0d", checks, errors);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        logic [31:0] rd;
        logic [31:0] exp_sum;
        clk            = 1'b0;
        rst            = 1'b1;
        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        paddr          = '0;
        pwdata         = '0;
        rsp            = '0;
        rsp.done       = 1'b1;
        seed           = 32'h7fba177c;
        checks         = 0;
        errors         = 0;
        cycles         = 0;
        early_activity = 0;
        started        = 1'b0;
        beat_addr      = '0;
        next_base      = '0;
        req_bytes      = 0;
        req_words      = 0;
        popped         = 0;

        // base, len in words, sink stall in cycles, expected sum
        loads[0] = '{32'h0000_1000, 16'd16, 16'd0,  32'd0};
        loads[1] = '{32'h0000_2040, 16'd4,  16'd0,  32'd0};
        loads[2] = '{32'h0001_0000, 16'd64, 16'd80, 32'd0};
        loads[3] = '{32'h8000_0010, 16'd20, 16'd0,  32'd0};
        loads[4] = '{32'hFFFF_FF00, 16'd40, 16'd30, 32'd0};
        limit = 2000;
        for (int i = 0; i < NUM_LOADS; i++) begin
            limit = limit + 200 * int'(loads[i].len);
        end

        repeat (8) @(negedge clk);
        rst = 1'b0;
        apb_read(wload_pkg::REG_STATUS, rd);
        check_value(rd, 32'd0, "STATUS after reset");
        check_value(32'(pready), 32'd1, "pready after reset");
        repeat (10) @(negedge clk);
        check_value(32'(early_activity), 32'd0, "go, read or pop before first start");
        started = 1'b1;

        for (int i = 0; i < NUM_LOADS; i++) begin
            exp_sum = '0;
            for (int w = 0; w < int'(loads[i].len); w++) begin
                exp_sum = exp_sum + word_at(loads[i].base + 32'(4 * w));
            end
            loads[i].exp_sum = exp_sum;
            next_base = loads[i].base;
            req_bytes = 0;
            apb_write(wload_pkg::REG_BASE, loads[i].base);
            apb_write(wload_pkg::REG_LEN, 32'(loads[i].len));
            if (loads[i].stall == 0) begin
                apb_write(wload_pkg::REG_CTRL, 32'h3);
                // second start lands while busy
                apb_write(wload_pkg::REG_CTRL, 32'h3);
            end else begin
                apb_write(wload_pkg::REG_CTRL, 32'h1);
                apb_read(wload_pkg::REG_SUM, rd);
                check_value(rd, 32'd0, "SUM not cleared by start");
                apb_read(wload_pkg::REG_COUNT, rd);
                check_value(rd, 32'd0, "COUNT not cleared by start");
                apb_write(wload_pkg::REG_CTRL, 32'h1);
                apb_read(wload_pkg::REG_STATUS, rd);
                check_value(rd, 32'h1, "STATUS while stalled");
                repeat (int'(loads[i].stall)) @(negedge clk);
                apb_write(wload_pkg::REG_CTRL, 32'h2);
                // this start arrives after the sink has taken words and must not clear them
                apb_write(wload_pkg::REG_CTRL, 32'h3);
            end
            rd = '0;
            while (rd[1] == 1'b0) begin
                apb_read(wload_pkg::REG_STATUS, rd);
            end
            check_value(rd, 32'h2, "STATUS at end of load");
            apb_read(wload_pkg::REG_SUM, rd);
            check_value(rd, loads[i].exp_sum, "SUM at end of load");
            apb_read(wload_pkg::REG_COUNT, rd);
            check_value(rd, 32'(loads[i].len), "COUNT at end of load");
            check_value(32'(req_bytes), 32'(loads[i].len) * 32'd4, "requested bytes total");
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* weight_load_top.f */
rtl/wload_pkg.sv
rtl/wload_apb_regs.sv
rtl/rmst_burst_ctrl.sv
rtl/rmst_word_unpack.sv
rtl/weight_fifo.sv
rtl/weight_tile_sink.sv
rtl/weight_load_top.sv
tests/tb_weight_load.sv

/* Bender.yml */
package:
  name: weight_load

sources:
  - files:
      - rtl/wload_pkg.sv
      - rtl/wload_apb_regs.sv
      - rtl/rmst_burst_ctrl.sv
      - rtl/rmst_word_unpack.sv
      - rtl/weight_fifo.sv
      - rtl/weight_tile_sink.sv
      - rtl/weight_load_top.sv
  - target: test
    files:
      - tests/tb_weight_load.sv
